// File: Makefile
TOP = tb_mycpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: project.f
rtl/mips_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/sram_handshake.sv
rtl/addr_map.sv
rtl/mips_core.sv
rtl/mycpu.sv
verif/sram_model.sv
verif/mycpu_checker.sv
verif/tb_mycpu.sv

// File: rtl/addr_map.sv
`timescale 1ns/1ns

module addr_map import mips_pkg::*; #(
    parameter bit DO_ADDR_TRANSLATION = 1'b1
) (
    input  word_t inst_vaddr,
    input  word_t data_vaddr,
    output word_t inst_paddr,
    output word_t data_paddr
);

    // kseg0 and kseg1 (0x8..0xb) both fold down onto the low 512MB
    function automatic word_t to_phys(word_t va);
        word_t pa;
        pa = va;
        if (va[31:30] == 2'b10) begin
            pa[31:29] = 3'b000;
        end
        return pa;
    endfunction

    if (DO_ADDR_TRANSLATION) begin : g_map
        assign inst_paddr = to_phys(inst_vaddr);
        assign data_paddr = to_phys(data_vaddr);
    end else begin : g_pass
        assign inst_paddr = inst_vaddr;
        assign data_paddr = data_vaddr;
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu import mips_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y,
    output logic    zero
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_OR: begin
                y = a | b;
            end
            // signed compare
            ALU_SLT: begin
                y = {31'b0, $signed(a) < $signed(b)};
            end
            // immediate sits in b, a is ignored
            ALU_LUI: begin
                y = {b[15:0], 16'h0000};
            end
            default: begin
                y = '0;
            end
        endcase
    end

    // beq/bne decision
    assign zero = (y == '0);

endmodule

// File: rtl/mips_core.sv
`timescale 1ns/1ns

module mips_core import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    output logic       inst_start,
    output word_t      inst_vaddr,
    input  logic       inst_done,
    input  word_t      inst_rdata,

    output logic       mem_start,
    output logic       mem_wr,
    output word_t      data_vaddr,
    output word_t      data_wdata,
    input  logic       mem_done,
    input  word_t      mem_rdata,

    output word_t      debug_wb_pc,
    output rwen_t      debug_wb_rf_wen,
    output creg_addr_t debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    core_state_t state;
    word_t       pc;
    word_t       ir;
    word_t       ir_pc;
    word_t       a_q;
    word_t       b_q;
    word_t       res_q;
    // bus request already issued for the current state
    logic        busy;

    opcode_t     opcode;
    funct_t      funct;
    creg_addr_t  rs;
    creg_addr_t  rt;
    creg_addr_t  rd;
    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_zext;

    alu_op_t     alu_op;
    word_t       alu_b;
    word_t       alu_y;
    logic        alu_zero;
    logic        rf_write;
    creg_addr_t  dest;
    logic        is_load;
    logic        is_store;

    word_t       rd1;
    word_t       rd2;
    word_t       pc_plus4;
    word_t       br_target;
    word_t       j_target;
    logic        br_taken;
    logic        wb_we;

    // instruction fields
    assign opcode   = ir[31:26];
    assign rs       = ir[25:21];
    assign rt       = ir[20:16];
    assign rd       = ir[15:11];
    assign funct    = ir[5:0];
    assign imm      = ir[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    always_comb begin
        alu_op   = ALU_ADD;
        alu_b    = b_q;
        rf_write = 1'b0;
        dest     = rt;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest     = rd;
                rf_write = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    // unsupported function retires as a nop
                    default: rf_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_b    = imm_sext;
                rf_write = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                alu_b    = imm_zext;
                rf_write = 1'b1;
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                alu_b    = imm_zext;
                rf_write = 1'b1;
            end
            OP_LW: begin
                alu_b    = imm_sext;
                rf_write = 1'b1;
                is_load  = 1'b1;
            end
            OP_SW: begin
                alu_b    = imm_sext;
                is_store = 1'b1;
            end
            // compare through subtraction
            OP_BEQ, OP_BNE: begin
                alu_op = ALU_SUB;
            end
            default: begin
            end
        endcase
    end

    regfile regfile_i (
        .clk (clk),
        .rst (rst),
        .ra1 (rs),
        .ra2 (rt),
        .rd1 (rd1),
        .rd2 (rd2),
        .we  (wb_we),
        .wa  (dest),
        .wd  (res_q)
    );

    alu alu_i (
        .op   (alu_op),
        .a    (a_q),
        .b    (alu_b),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // next pc candidates
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], ir[25:0], 2'b00};
    assign br_taken  = (opcode == OP_BEQ && alu_zero) || (opcode == OP_BNE && !alu_zero);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_FETCH;
            pc    <= RESET_PC;
            busy  <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (inst_start) begin
                        busy <= 1'b1;
                    end
                    if (inst_done) begin
                        busy  <= 1'b0;
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    state <= ST_EXEC;
                end
                ST_EXEC: begin
                    if (opcode == OP_J) begin
                        pc <= j_target;
                    end else if (br_taken) begin
                        pc <= br_target;
                    end else begin
                        pc <= pc_plus4;
                    end
                    state <= (is_load || is_store) ? ST_MEM : ST_WB;
                end
                ST_MEM: begin
                    if (mem_start) begin
                        busy <= 1'b1;
                    end
                    if (mem_done) begin
                        busy  <= 1'b0;
                        state <= is_load ? ST_WB : ST_FETCH;
                    end
                end
                ST_WB: begin
                    state <= ST_FETCH;
                end
                default: begin
                    state <= ST_FETCH;
                end
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        case (state)
            ST_FETCH: begin
                if (inst_done) begin
                    ir    <= inst_rdata;
                    ir_pc <= pc;
                end
            end
            ST_DECODE: begin
                a_q <= rd1;
                b_q <= rd2;
            end
            ST_EXEC: begin
                res_q <= alu_y;
            end
            ST_MEM: begin
                if (mem_done && is_load) begin
                    res_q <= mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

    assign inst_start = (state == ST_FETCH) && !busy;
    assign inst_vaddr = pc;

    // address stays in res_q until the load data arrives
    assign mem_start  = (state == ST_MEM) && !busy;
    assign mem_wr     = is_store;
    assign data_vaddr = res_q;
    assign data_wdata = b_q;

    assign wb_we             = (state == ST_WB) && rf_write;
    assign debug_wb_pc       = ir_pc;
    assign debug_wb_rf_wen   = (wb_we && dest != '0) ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = res_q;

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [3:0]  rwen_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_WB
    } core_state_t;

    // boot vector in kseg1
    localparam word_t RESET_PC = 32'hbfc00000;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function codes for SPECIAL
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

// File: rtl/mycpu.sv
`timescale 1ns/1ns

module mycpu import mips_pkg::*; #(
    parameter bit DO_ADDR_TRANSLATION = 1'b1
) (
    input  logic       clk,
    input  logic       rst,

    output logic       inst_req,
    output logic       inst_wr,
    output logic [1:0] inst_size,
    output word_t      inst_addr,
    output word_t      inst_wdata,
    input  word_t      inst_rdata,
    input  logic       inst_addr_ok,
    input  logic       inst_data_ok,

    output logic       data_req,
    output logic       data_wr,
    output logic [1:0] data_size,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  word_t      data_rdata,
    input  logic       data_addr_ok,
    input  logic       data_data_ok,

    output word_t      debug_wb_pc,
    output rwen_t      debug_wb_rf_wen,
    output creg_addr_t debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic  inst_start;
    logic  inst_done;
    word_t inst_vaddr;
    word_t inst_rdata_core;

    logic  mem_start;
    logic  mem_wr;
    logic  mem_done;
    word_t data_vaddr;
    word_t data_wdata_core;
    word_t mem_rdata;

    mips_core core_i (
        .clk               (clk),
        .rst               (rst),
        .inst_start        (inst_start),
        .inst_vaddr        (inst_vaddr),
        .inst_done         (inst_done),
        .inst_rdata        (inst_rdata_core),
        .mem_start         (mem_start),
        .mem_wr            (mem_wr),
        .data_vaddr        (data_vaddr),
        .data_wdata        (data_wdata_core),
        .mem_done          (mem_done),
        .mem_rdata         (mem_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // fetch side never writes
    sram_handshake i_handshake (
        .clk       (clk),
        .rst       (rst),
        .start     (inst_start),
        .wr_in     (1'b0),
        .wdata_in  ('0),
        .addr_ok   (inst_addr_ok),
        .data_ok   (inst_data_ok),
        .rdata     (inst_rdata),
        .req       (inst_req),
        .wr        (inst_wr),
        .size      (inst_size),
        .wdata     (inst_wdata),
        .done      (inst_done),
        .rdata_out (inst_rdata_core)
    );

    sram_handshake d_handshake (
        .clk       (clk),
        .rst       (rst),
        .start     (mem_start),
        .wr_in     (mem_wr),
        .wdata_in  (data_wdata_core),
        .addr_ok   (data_addr_ok),
        .data_ok   (data_data_ok),
        .rdata     (data_rdata),
        .req       (data_req),
        .wr        (data_wr),
        .size      (data_size),
        .wdata     (data_wdata),
        .done      (mem_done),
        .rdata_out (mem_rdata)
    );

    addr_map #(
        .DO_ADDR_TRANSLATION (DO_ADDR_TRANSLATION)
    ) addr_map_i (
        .inst_vaddr (inst_vaddr),
        .data_vaddr (data_vaddr),
        .inst_paddr (inst_addr),
        .data_paddr (data_addr)
    );

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ns

module regfile import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  creg_addr_t ra1,
    input  creg_addr_t ra2,
    output word_t      rd1,
    output word_t      rd2,
    input  logic       we,
    input  creg_addr_t wa,
    input  word_t      wd
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // $zero reads as zero whatever was written
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: rtl/sram_handshake.sv
`timescale 1ns/1ns

module sram_handshake import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       wr_in,
    input  word_t      wdata_in,
    input  logic       addr_ok,
    input  logic       data_ok,
    input  word_t      rdata,
    output logic       req,
    output logic       wr,
    output logic [1:0] size,
    output word_t      wdata,
    output logic       done,
    output word_t      rdata_out
);

    // 4-byte transfer encoding
    localparam logic [1:0] SIZE_WORD = 2'b10;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_WAIT
    } hs_state_t;

    hs_state_t state;
    logic      wr_q;
    word_t     wdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
            wr_q  <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (start) begin
                        state <= HS_REQ;
                        wr_q  <= wr_in;
                    end
                end
                // hold the request until the slave takes the address
                HS_REQ: begin
                    if (addr_ok) begin
                        state <= HS_WAIT;
                    end
                end
                HS_WAIT: begin
                    if (data_ok) begin
                        state <= HS_IDLE;
                    end
                end
                default: begin
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == HS_IDLE && start) begin
            wdata_q <= wdata_in;
        end
    end

    assign req       = (state == HS_REQ);
    assign wr        = wr_q;
    assign size      = SIZE_WORD;
    assign wdata     = wdata_q;
    assign done      = (state == HS_WAIT) && data_ok;
    assign rdata_out = rdata;

endmodule

// File: verif/mycpu_checker.sv
`timescale 1ns/1ns

module mycpu_checker import mips_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       inst_req,
    input logic       inst_wr,
    input word_t      inst_addr,
    input logic       inst_addr_ok,
    input logic       data_req,
    input logic       data_wr,
    input word_t      data_addr,
    input logic       data_addr_ok,
    input rwen_t      debug_wb_rf_wen,
    input creg_addr_t debug_wb_rf_wnum
);

    int unsigned fail_count = 0;

    // request, address and direction held until accepted
    inst_hold: assert property (@(posedge clk) disable iff (rst)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr) && $stable(inst_wr))
        else begin
            fail_count++;
            $error("instruction request changed before addr_ok");
        end

    data_hold: assert property (@(posedge clk) disable iff (rst)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr) && $stable(data_wr))
        else begin
            fail_count++;
            $error("data request changed before addr_ok");
        end

    // fetch bus only reads
    inst_read: assert property (@(posedge clk) disable iff (rst)
        inst_req |-> !inst_wr)
        else begin
            fail_count++;
            $error("write request on the instruction bus");
        end

    // kseg0/kseg1 folded to physical
    inst_phys: assert property (@(posedge clk) disable iff (rst)
        inst_req |-> inst_addr[31:29] == 3'b000)
        else begin
            fail_count++;
            $error("instruction address not translated");
        end

    data_phys: assert property (@(posedge clk) disable iff (rst)
        data_req |-> data_addr[31:29] == 3'b000)
        else begin
            fail_count++;
            $error("data address not translated");
        end

    zero_reg: assert property (@(posedge clk) disable iff (rst)
        debug_wb_rf_wnum == '0 |-> debug_wb_rf_wen == '0)
        else begin
            fail_count++;
            $error("write strobe raised for register 0");
        end

endmodule

bind mycpu mycpu_checker checker_i (
    .clk              (clk),
    .rst              (rst),
    .inst_req         (inst_req),
    .inst_wr          (inst_wr),
    .inst_addr        (inst_addr),
    .inst_addr_ok     (inst_addr_ok),
    .data_req         (data_req),
    .data_wr          (data_wr),
    .data_addr        (data_addr),
    .data_addr_ok     (data_addr_ok),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

// File: verif/sram_model.sv
`timescale 1ns/1ns

module sram_model import mips_pkg::*; #(
    parameter int IMAGE_WORDS = 16
) (
    input  logic  clk,
    input  logic  load,
    input  word_t image [IMAGE_WORDS],

    input  logic  inst_req,
    input  logic  inst_wr,
    input  word_t inst_addr,
    input  word_t inst_wdata,
    output word_t inst_rdata,
    output logic  inst_addr_ok,
    output logic  inst_data_ok,

    input  logic  data_req,
    input  logic  data_wr,
    input  word_t data_addr,
    input  word_t data_wdata,
    output word_t data_rdata,
    output logic  data_addr_ok,
    output logic  data_data_ok
);

    word_t  mem [1024];
    integer seed = 32'h52e86573;

    // per-bus slave state, i_ for fetch and d_ for data
    logic       i_aok;
    logic       i_dok;
    word_t      i_rdata;
    logic       i_busy;
    int         i_aw;
    int         i_dw;
    logic [9:0] i_idx;
    logic       d_aok;
    logic       d_dok;
    word_t      d_rdata;
    logic       d_busy;
    int         d_aw;
    int         d_dw;
    logic [9:0] d_idx;

    // 0 to 3 extra cycles
    function automatic int pick_delay();
        return $random(seed) & 3;
    endfunction

    // one clock of slave behavior from the values sampled at the edge
    task automatic serve_bus(
        input  logic       req,
        input  logic       wr,
        input  word_t      addr,
        input  word_t      wdata,
        inout  logic       aok,
        inout  logic       dok,
        inout  word_t      rdata,
        inout  logic       busy,
        inout  int         addr_wait,
        inout  int         data_wait,
        inout  logic [9:0] idx
    );
        // data_ok is a single-cycle pulse
        if (dok) begin
            dok  = 1'b0;
            busy = 1'b0;
        end
        if (req && aok) begin
            aok       = 1'b0;
            busy      = 1'b1;
            idx       = addr[11:2];
            data_wait = pick_delay();
            addr_wait = pick_delay();
            if (wr) begin
                mem[addr[11:2]] = wdata;
            end
        end else if (req && !busy) begin
            if (addr_wait == 0) begin
                aok = 1'b1;
            end else begin
                addr_wait--;
            end
        end
        // earliest return is the cycle after acceptance
        if (busy && !dok) begin
            if (data_wait == 0) begin
                dok   = 1'b1;
                rdata = mem[idx];
            end else begin
                data_wait--;
            end
        end
    endtask

    initial begin
        inst_rdata   = '0;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        data_rdata   = '0;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        i_aok   = 1'b0;
        i_dok   = 1'b0;
        i_rdata = '0;
        i_busy  = 1'b0;
        i_dw    = 0;
        i_idx   = '0;
        d_aok   = 1'b0;
        d_dok   = 1'b0;
        d_rdata = '0;
        d_busy  = 1'b0;
        d_dw    = 0;
        d_idx   = '0;
        // background pattern, unique per word
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hdead0000 | i;
        end
        i_aw = pick_delay();
        d_aw = pick_delay();
        forever begin
            @(posedge clk);
            if (load) begin
                for (int i = 0; i < IMAGE_WORDS; i++) begin
                    mem[i] = image[i];
                end
            end
            serve_bus(inst_req, inst_wr, inst_addr, inst_wdata,
                      i_aok, i_dok, i_rdata, i_busy, i_aw, i_dw, i_idx);
            serve_bus(data_req, data_wr, data_addr, data_wdata,
                      d_aok, d_dok, d_rdata, d_busy, d_aw, d_dw, d_idx);
            #1;
            inst_addr_ok = i_aok;
            inst_data_ok = i_dok;
            inst_rdata   = i_rdata;
            data_addr_ok = d_aok;
            data_data_ok = d_dok;
            data_rdata   = d_rdata;
        end
    end

endmodule

// File: verif/tb_mycpu.sv
`timescale 1ns/1ns

module tb_mycpu import mips_pkg::*; ();

    localparam int RETIRE_TIMEOUT = 200;
    localparam int PROG_WORDS     = 23;
    localparam int NUM_RETIRE     = 13;

    // 4-byte transfer code on both buses
    localparam logic [1:0] WORD_SIZE = 2'b10;

    typedef struct packed {
        word_t      pc;
        creg_addr_t wnum;
        word_t      wdata;
    } retire_t;

    // program at the boot vector, one word per instruction
    localparam word_t PROG [PROG_WORDS] = '{
        // lui, ori, addiu, then the R-type group
        32'h3c011234, 32'h34215678, 32'h2402ff00, 32'h00221821,
        32'h00222023, 32'h00222824, 32'h00223025, 32'h0041382a,
        32'h0022402a,
        // lui r10 0xa000, sw r3 0x100(r10), lw r9 0x100(r10)
        32'h3c0aa000, 32'had430100, 32'h8d490100,
        // beq taken over 0x34, bne not taken, addiu r12
        32'h11230001, 32'h240b0bad, 32'h15230001, 32'h240c0042,
        // j 0x50 over three fillers
        32'h0bf00014, 32'h240d0bad, 32'h240d0bad, 32'h240d0bad,
        // addiu r0, addu r14 r0 r0, then spin
        32'h24000055, 32'h00007021, 32'h0bf00016
    };

    localparam retire_t EXPECT [NUM_RETIRE] = '{
        '{32'hbfc00000, 5'd1,  32'h12340000},
        '{32'hbfc00004, 5'd1,  32'h12345678},
        '{32'hbfc00008, 5'd2,  32'hffffff00},
        '{32'hbfc0000c, 5'd3,  32'h12345578},
        '{32'hbfc00010, 5'd4,  32'h12345778},
        '{32'hbfc00014, 5'd5,  32'h12345600},
        '{32'hbfc00018, 5'd6,  32'hffffff78},
        '{32'hbfc0001c, 5'd7,  32'h00000001},
        '{32'hbfc00020, 5'd8,  32'h00000000},
        '{32'hbfc00024, 5'd10, 32'ha0000000},
        '{32'hbfc0002c, 5'd9,  32'h12345578},
        '{32'hbfc0003c, 5'd12, 32'h00000042},
        '{32'hbfc00054, 5'd14, 32'h00000000}
    };

    logic       clk;
    logic       rst;
    logic       load;
    word_t      prog_image [PROG_WORDS];

    logic       inst_req;
    logic       inst_wr;
    logic [1:0] inst_size;
    word_t      inst_addr;
    word_t      inst_wdata;
    word_t      inst_rdata;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    logic       data_req;
    logic       data_wr;
    logic [1:0] data_size;
    word_t      data_addr;
    word_t      data_wdata;
    word_t      data_rdata;
    logic       data_addr_ok;
    logic       data_data_ok;
    word_t      debug_wb_pc;
    rwen_t      debug_wb_rf_wen;
    creg_addr_t debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    mycpu #(
        .DO_ADDR_TRANSLATION (1'b1)
    ) dut_i (
        .clk               (clk),
        .rst               (rst),
        .inst_req          (inst_req),
        .inst_wr           (inst_wr),
        .inst_size         (inst_size),
        .inst_addr         (inst_addr),
        .inst_wdata        (inst_wdata),
        .inst_rdata        (inst_rdata),
        .inst_addr_ok      (inst_addr_ok),
        .inst_data_ok      (inst_data_ok),
        .data_req          (data_req),
        .data_wr           (data_wr),
        .data_size         (data_size),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata),
        .data_addr_ok      (data_addr_ok),
        .data_data_ok      (data_data_ok),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    sram_model #(
        .IMAGE_WORDS (PROG_WORDS)
    ) mem_i (
        .clk          (clk),
        .load         (load),
        .image        (prog_image),
        .inst_req     (inst_req),
        .inst_wr      (inst_wr),
        .inst_addr    (inst_addr),
        .inst_wdata   (inst_wdata),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg(input string name, input creg_addr_t expected,
                             input creg_addr_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "register number mismatch");
        end
    endtask

    task automatic check_wen(input string name, input rwen_t expected, input rwen_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "byte enable mismatch");
        end
    endtask

    task automatic check_size(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "transfer size mismatch");
        end
    endtask

    // first fetch request within two cycles of reset release
    task automatic wait_first_fetch();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!inst_req && cycles < 2) begin
            @(negedge clk);
            cycles++;
        end
        if (!inst_req) begin
            $display("no instruction request after reset release");
            $display("Finished with errors");
            $fatal(1, "fetch did not start");
        end
    endtask

    task automatic wait_retire(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (debug_wb_rf_wen == 4'h0 && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (debug_wb_rf_wen == 4'h0) begin
            $display("timed out waiting for register write %0d", idx);
            $display("Finished with errors");
            $fatal(1, "no write-back within %0d cycles", RETIRE_TIMEOUT);
        end
    endtask

    initial begin
        rst         = 1'b1;
        load        = 1'b0;
        prog_image  = PROG;
        @(posedge clk);
        #1;
        load = 1'b1;
        @(posedge clk);
        #1;
        load = 1'b0;
        repeat (14) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_first_fetch();
        // walk the retirement table in program order
        for (int i = 0; i < NUM_RETIRE; i++) begin
            wait_retire(i);
            check_word($sformatf("retire %0d pc", i), EXPECT[i].pc, debug_wb_pc);
            check_reg($sformatf("retire %0d wnum", i), EXPECT[i].wnum, debug_wb_rf_wnum);
            check_word($sformatf("retire %0d wdata", i), EXPECT[i].wdata, debug_wb_rf_wdata);
            check_wen($sformatf("retire %0d wen", i), 4'hf, debug_wb_rf_wen);
            check_size($sformatf("retire %0d inst size", i), WORD_SIZE, inst_size);
            check_size($sformatf("retire %0d data size", i), WORD_SIZE, data_size);
            // fetch bus carries no write data
            check_word($sformatf("retire %0d inst wdata", i), '0, inst_wdata);
        end
        if (dut_i.checker_i.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
